/* ex_stage.f */
design/xlate_pkg.sv
design/ex_pkg.sv
design/ex_alu.sv
design/ex_muldiv.sv
design/ex_addr_gen.sv
design/ex_stage.sv
dv/ex_muldiv_sva.sv
dv/ex_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= ex_stage.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
STEP_BITS ?= 2
FAIL_MSG  ?= Done: errors found
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GMD_STEP_BITS=$(STEP_BITS) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/ex_stage_tb.sv */
`timescale 1ns/100ps

module ex_stage_tb #(
    parameter int MD_STEP_BITS = 2
);
    import ex_pkg::*;
    import xlate_pkg::*;

    localparam int TIMEOUT   = 200;
    localparam int NUM_INSTR = 400;

    logic       clk;
    logic       rst;
    logic       advance;
    logic       flush;
    logic       ready;
    ex_in_t     instr;
    xlate_csr_t csr;
    ex_out_t    out_rec;

    integer     seed;
    int         errors;
    int         checks;
    logic       stuck;
    ex_out_t    exp_rec;
    logic       exp_known;

    ex_stage #(.MD_STEP_BITS(MD_STEP_BITS)) dut (
        .clk      (clk),
        .rst      (rst),
        .advance_i(advance),
        .flush_i  (flush),
        .ready_o  (ready),
        .in_i     (instr),
        .csr_i    (csr),
        .out_o    (out_rec)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Random stimulus
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic rand_advance();
        return (rand32() % 32'd10) < 32'd7;
    endfunction

    // Corner operands now and then
    function automatic logic [31:0] rand_operand();
        logic [31:0] pick;
        pick = rand32();
        case (pick[4:0])
            5'd0:    return 32'h0000_0000;
            5'd1:    return 32'hffff_ffff;
            5'd2:    return 32'h8000_0000;
            default: return rand32();
        endcase
    endfunction

    function automatic ex_in_t rand_instr();
        ex_in_t      r;
        logic [31:0] pick;
        pick    = rand32() % 32'd25;
        r.op    = ex_op_e'(pick[4:0]);
        r.src1  = rand_operand();
        r.src2  = rand_operand();
        r.imm   = rand_operand();
        r.pc    = rand32();
        pick    = rand32();
        r.waddr = pick[4:0];
        r.wreg  = pick[5];
        r.valid = (pick[11:8] != 4'd0);
        if (pick[12]) begin
            r.src1[1:0] = 2'b00;
            r.imm[1:0]  = 2'b00;
        end
        // Bubbles carry no multi-cycle op
        if (!r.valid && (r.op inside {[OP_MUL:OP_MODU]})) r.op = OP_NOP;
        return r;
    endfunction

    function automatic xlate_csr_t rand_csr(logic [31:0] addr);
        xlate_csr_t  c;
        logic [31:0] pick;
        pick       = rand32();
        c.da       = pick[0];
        c.pg       = pick[1];
        c.plv      = pick[3:2];
        c.dmw0.raw = rand32();
        c.dmw1.raw = rand32();
        // Steer windows onto the access half of the time
        if (pick[4]) c.dmw0.raw[31:29] = addr[31:29];
        if (pick[5]) c.dmw1.raw[31:29] = addr[31:29];
        return c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] model_md(ex_op_e op, logic [31:0] a, logic [31:0] b);
        logic [63:0]        prod_s;
        logic [63:0]        prod_u;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               ovf;
        sa     = a;
        sb     = b;
        prod_s = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        prod_u = {32'b0, a} * {32'b0, b};
        ovf    = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            OP_MUL:   return prod_u[31:0];
            OP_MULH:  return prod_s[63:32];
            OP_MULHU: return prod_u[63:32];
            OP_DIV: begin
                if (b == 32'b0) return '1;
                if (ovf) return a;
                return sa / sb;
            end
            OP_DIVU: begin
                if (b == 32'b0) return '1;
                return a / b;
            end
            OP_MOD: begin
                if (b == 32'b0) return a;
                if (ovf) return 32'b0;
                return sa % sb;
            end
            default: begin
                if (b == 32'b0) return a;
                return a % b;
            end
        endcase
    endfunction

    function automatic logic [31:0] model_wdata(ex_op_e op, logic [31:0] a, logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        if (op inside {[OP_MUL:OP_MODU]}) return model_md(op, a, b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return sa >>> b[4:0];
            OP_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            OP_LUI:  return b;
            default: return 32'b0;
        endcase
    endfunction

    // Window CSR has vseg in bits 31:29 and the plv3 and plv0 enables in bits 3 and 0
    function automatic logic window_hit(logic [31:0] dmw, logic [1:0] plv, logic [31:0] addr);
        logic en;
        en = ((plv == 2'd0) && dmw[0]) || ((plv == 2'd3) && dmw[3]);
        return en && (addr[31:29] == dmw[31:29]);
    endfunction

    function automatic ex_out_t model_out(ex_in_t i, xlate_csr_t c);
        ex_out_t     o;
        logic [31:0] addr;
        logic        half;
        logic        word;
        logic        mem;
        logic        hit0;
        logic        hit1;
        addr            = i.src1 + i.imm;
        half            = i.op inside {OP_LD_H, OP_ST_H};
        word            = i.op inside {OP_LD_W, OP_ST_W};
        mem             = half || word || (i.op inside {OP_LD_B, OP_ST_B});
        hit0            = window_hit(c.dmw0.raw, c.plv, addr);
        hit1            = window_hit(c.dmw1.raw, c.plv, addr);
        o.valid         = i.valid;
        o.op            = i.op;
        o.wdata         = model_wdata(i.op, i.src1, i.src2);
        o.waddr         = i.waddr;
        o.excp_ale      = (half && addr[0]) || (word && (addr[1:0] != 2'b00));
        o.wreg          = i.wreg && !o.excp_ale;
        o.mem_addr      = addr;
        o.st_data       = (i.op inside {OP_ST_B, OP_ST_H, OP_ST_W}) ? i.src2 : 32'b0;
        o.xreq.fetch    = i.valid && mem;
        o.xreq.trans_en = i.valid && mem && c.pg && !c.da && !hit0 && !hit1;
        o.xreq.dmw0_hit = hit0;
        o.xreq.dmw1_hit = hit1;
        o.xreq.vaddr    = addr;
        return o;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_out(input string name, input ex_out_t exp, input ex_out_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_xreq(input string name, input xlate_req_t exp, input xlate_req_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Before the first accepted record only valid is defined
    task automatic check_held(input string name);
        if (exp_known) begin
            check_out(name, exp_rec, out_rec);
        end else begin
            check_word(name, 32'd0, {31'b0, out_rec.valid});
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequences entered and left on a falling edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_instr(input string name, input ex_in_t i, input xlate_csr_t c);
        ex_out_t exp;
        int      wait_cnt;
        logic    moved;
        exp      = model_out(i, c);
        instr    = i;
        csr      = c;
        flush    = 1'b0;
        moved    = 1'b0;
        wait_cnt = 0;
        while (!moved && !stuck) begin
            advance = rand_advance();
            #1;
            if (wait_cnt == 0 && i.valid && (i.op inside {[OP_MUL:OP_MODU]}))
                check_word({name, " ready"}, 32'd0, {31'b0, ready});
            moved = advance && ready;
            @(negedge clk);
            if (moved) begin
                check_word({name, " wdata"}, exp.wdata, out_rec.wdata);
                check_xreq({name, " xreq"}, exp.xreq, out_rec.xreq);
                check_out(name, exp, out_rec);
                exp_rec   = exp;
                exp_known = 1'b1;
            end else begin
                check_held({name, " hold"});
                wait_cnt++;
                if (wait_cnt >= TIMEOUT) begin
                    $display("ERROR: %s was not accepted within %0d cycles", name, TIMEOUT);
                    errors++;
                    stuck = 1'b1;
                end
            end
        end
    endtask

    task automatic flush_cycle(input string name);
        flush         = 1'b1;
        advance       = rand_advance();
        exp_rec.valid = 1'b0;
        @(negedge clk);
        flush = 1'b0;
        check_held(name);
    endtask

    task automatic run_md_case(input string name, input ex_op_e op, input logic [31:0] a,
                               input logic [31:0] b);
        ex_in_t i;
        i       = rand_instr();
        i.valid = 1'b1;
        i.op    = op;
        i.src1  = a;
        i.src2  = b;
        run_instr(name, i, rand_csr(i.src1 + i.imm));
    endtask

    // Divide cut short by a flush and followed by a fresh multi-cycle op
    task automatic flush_divide();
        ex_in_t i;
        i       = rand_instr();
        i.valid = 1'b1;
        i.op    = OP_DIV;
        instr   = i;
        csr     = rand_csr(i.src1 + i.imm);
        advance = 1'b0;
        repeat (5) @(negedge clk);
        flush_cycle("flush_div");
        run_md_case("after_flush", OP_DIVU, rand_operand(), rand_operand());
    endtask

    initial begin
        ex_in_t next;
        clk       = 1'b0;
        rst       = 1'b1;
        advance   = 1'b0;
        flush     = 1'b0;
        instr     = '0;
        csr       = '0;
        seed      = 32'hfdee_0802;
        errors    = 0;
        checks    = 0;
        stuck     = 1'b0;
        exp_rec   = '0;
        exp_known = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_word("reset_valid", 32'd0, {31'b0, out_rec.valid});
        check_word("reset_ready", 32'd1, {31'b0, ready});
        @(negedge clk);

        run_md_case("div_ovf", OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        run_md_case("mod_ovf", OP_MOD, 32'h8000_0000, 32'hffff_ffff);
        run_md_case("div_zero", OP_DIV, rand32(), 32'b0);
        run_md_case("divu_zero", OP_DIVU, rand32(), 32'b0);
        run_md_case("mod_zero", OP_MOD, rand32(), 32'b0);
        run_md_case("modu_zero", OP_MODU, rand32(), 32'b0);
        flush_divide();

        for (int n = 0; n < NUM_INSTR; n++) begin
            if (stuck) break;
            if ((rand32() % 32'd16) == 32'd0) flush_cycle($sformatf("flush_%0d", n));
            next = rand_instr();
            run_instr($sformatf("rand_%0d", n), next, rand_csr(next.src1 + next.imm));
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* dv/ex_muldiv_sva.sv */
`timescale 1ns/100ps

module ex_muldiv_sva (
    input logic            clk,
    input logic            rst,
    input logic            req_i,
    input ex_pkg::md_req_t req_data_i,
    input logic            ack_i
);

    ////////////////////////////////////////////////////////////////////////////
    // Four-phase req/ack
    ////////////////////////////////////////////////////////////////////////////
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack_i) |-> req_i)
        else $error("ack rose with req low");

    // Operands frozen for the whole request
    req_data_stable: assert property (@(posedge clk) disable iff (rst)
        req_i && $past(req_i) |-> $stable(req_data_i))
        else $error("request data changed while req was high");

    req_held_to_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(req_i) |-> $past(ack_i))
        else $error("req dropped before ack");

    ack_held_to_req_low: assert property (@(posedge clk) disable iff (rst)
        $fell(ack_i) |-> !$past(req_i))
        else $error("ack dropped while req was still high");

endmodule

bind ex_muldiv ex_muldiv_sva u_muldiv_sva (
    .clk       (clk),
    .rst       (rst),
    .req_i     (req_i),
    .req_data_i(req_data_i),
    .ack_i     (ack_o)
);

/* design/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage #(
    parameter int MD_STEP_BITS = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance_i,
    input  logic                  flush_i,
    output logic                  ready_o,
    input  ex_pkg::ex_in_t        in_i,
    input  xlate_pkg::xlate_csr_t csr_i,
    output ex_pkg::ex_out_t       out_o
);
    import ex_pkg::*;
    import xlate_pkg::*;

    logic        is_md;
    logic        is_store;
    md_op_e      md_op;
    md_req_t     md_req_data;
    logic        md_req;
    logic        md_ack;
    logic [31:0] md_result;
    logic        md_start;
    logic        md_started;
    logic        md_done;
    logic        md_discard;
    logic [31:0] md_result_q;
    logic [31:0] alu_result;
    logic [31:0] mem_addr;
    logic        excp_ale;
    xlate_req_t  xreq;
    ex_out_t     ex_rec;

    assign is_md    = in_i.op inside {[OP_MUL:OP_MODU]};
    assign is_store = in_i.op inside {OP_ST_B, OP_ST_H, OP_ST_W};

    always_comb begin
        case (in_i.op)
            OP_MULH:  md_op = MD_MULH;
            OP_MULHU: md_op = MD_MULHU;
            OP_DIV:   md_op = MD_DIV;
            OP_DIVU:  md_op = MD_DIVU;
            OP_MOD:   md_op = MD_MOD;
            OP_MODU:  md_op = MD_MODU;
            default:  md_op = MD_MUL;
        endcase
    end

    ex_alu u_alu (
        .op_i    (in_i.op),
        .src1_i  (in_i.src1),
        .src2_i  (in_i.src2),
        .imm_i   (in_i.imm),
        .result_o(alu_result)
    );

    ex_addr_gen u_addr_gen (
        .op_i      (in_i.op),
        .base_i    (in_i.src1),
        .imm_i     (in_i.imm),
        .valid_i   (in_i.valid),
        .csr_i     (csr_i),
        .addr_o    (mem_addr),
        .excp_ale_o(excp_ale),
        .xreq_o    (xreq)
    );

    ex_muldiv #(.MD_STEP_BITS(MD_STEP_BITS)) u_muldiv (
        .clk       (clk),
        .rst       (rst),
        .req_i     (md_req),
        .req_data_i(md_req_data),
        .ack_o     (md_ack),
        .result_o  (md_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Multi-cycle sequencing
    ////////////////////////////////////////////////////////////////////////////
    assign ready_o  = !(in_i.valid && is_md && !md_done);
    assign md_start = in_i.valid && is_md && !md_started && !md_done
                      && !md_req && !md_ack && !flush_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            md_req     <= 1'b0;
            md_started <= 1'b0;
            md_done    <= 1'b0;
            md_discard <= 1'b0;
        end else begin
            if (md_req && md_ack) begin
                md_req     <= 1'b0;
                md_discard <= 1'b0;
                if (!md_discard) md_done <= 1'b1;
            end else if (md_start) begin
                md_req     <= 1'b1;
                md_started <= 1'b1;
            end
            if (flush_i) begin
                md_started <= 1'b0;
                md_done    <= 1'b0;
                // Outstanding request finishes but its result is dropped
                if (md_req && !md_ack) md_discard <= 1'b1;
            end else if (advance_i && ready_o) begin
                md_started <= 1'b0;
                md_done    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (md_start) md_req_data <= '{op: md_op, src1: in_i.src1, src2: in_i.src2};
        if (md_req && md_ack) md_result_q <= md_result;
    end

    always_comb begin
        ex_rec          = '0;
        ex_rec.valid    = in_i.valid;
        ex_rec.op       = in_i.op;
        ex_rec.wdata    = is_md ? md_result_q : alu_result;
        ex_rec.waddr    = in_i.waddr;
        ex_rec.wreg     = in_i.wreg && !excp_ale;
        ex_rec.mem_addr = mem_addr;
        ex_rec.st_data  = is_store ? in_i.src2 : 32'b0;
        ex_rec.excp_ale = excp_ale;
        ex_rec.xreq     = xreq;
    end

    // Execute-to-memory register
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            out_o.valid <= 1'b0;
        end else if (advance_i && ready_o) begin
            out_o <= ex_rec;
        end
    end

endmodule

/* design/ex_addr_gen.sv */
`timescale 1ns/100ps

module ex_addr_gen (
    input  ex_pkg::ex_op_e         op_i,
    input  logic [31:0]            base_i,
    input  logic [31:0]            imm_i,
    input  logic                   valid_i,
    input  xlate_pkg::xlate_csr_t  csr_i,
    output logic [31:0]            addr_o,
    output logic                   excp_ale_o,
    output xlate_pkg::xlate_req_t  xreq_o
);
    import ex_pkg::*;

    logic is_mem;
    logic is_half;
    logic is_word;
    logic plv0;
    logic plv3;
    logic dmw0_hit;
    logic dmw1_hit;
    logic pg_mode;

    assign addr_o  = base_i + imm_i;
    assign is_half = op_i inside {OP_LD_H, OP_ST_H};
    assign is_word = op_i inside {OP_LD_W, OP_ST_W};
    assign is_mem  = is_half || is_word || (op_i inside {OP_LD_B, OP_ST_B});

    assign excp_ale_o = (is_half && addr_o[0]) || (is_word && (addr_o[1:0] != 2'b00));

    ////////////////////////////////////////////////////////////////////////////
    // Direct-mapped windows
    ////////////////////////////////////////////////////////////////////////////
    assign plv0 = (csr_i.plv == 2'd0);
    assign plv3 = (csr_i.plv == 2'd3);

    assign dmw0_hit = ((plv0 && csr_i.dmw0.f.plv0) || (plv3 && csr_i.dmw0.f.plv3))
                      && (addr_o[31:29] == csr_i.dmw0.f.vseg);
    assign dmw1_hit = ((plv0 && csr_i.dmw1.f.plv0) || (plv3 && csr_i.dmw1.f.plv3))
                      && (addr_o[31:29] == csr_i.dmw1.f.vseg);

    assign pg_mode = csr_i.pg && !csr_i.da;

    assign xreq_o.fetch    = valid_i && is_mem;
    assign xreq_o.trans_en = valid_i && is_mem && pg_mode && !dmw0_hit && !dmw1_hit;
    assign xreq_o.dmw0_hit = dmw0_hit;
    assign xreq_o.dmw1_hit = dmw1_hit;
    assign xreq_o.vaddr    = addr_o;

endmodule

/* design/ex_muldiv.sv */
`timescale 1ns/100ps

module ex_muldiv #(
    parameter int MD_STEP_BITS = 1
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_i,
    input  ex_pkg::md_req_t req_data_i,
    output logic            ack_o,
    output logic [31:0]     result_o
);
    import ex_pkg::*;

    localparam int STEPS = 32 / MD_STEP_BITS;

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_ACK
    } state_e;

    state_e      state;
    logic [5:0]  cnt;
    logic        start;
    logic        is_signed;
    logic        a_neg;
    logic        b_neg;
    logic [31:0] a_mag;
    logic [31:0] b_mag;

    md_op_e      op_q;
    logic        neg_q;
    logic        neg_rem_q;
    logic [63:0] prod;
    logic [63:0] mcand;
    logic [31:0] mplier;
    logic [32:0] rem;
    logic [31:0] quo;
    logic [31:0] dvsr;
    logic [63:0] prod_nx;
    logic [32:0] rem_nx;
    logic [31:0] quo_nx;
    logic [63:0] prod_fix;

    assign start     = req_i && (state == S_IDLE);
    assign ack_o     = (state == S_ACK);
    assign is_signed = req_data_i.op inside {MD_MULH, MD_DIV, MD_MOD};
    assign a_neg     = is_signed && req_data_i.src1[31];
    assign b_neg     = is_signed && req_data_i.src2[31];
    assign a_mag     = a_neg ? -req_data_i.src1 : req_data_i.src1;
    assign b_mag     = b_neg ? -req_data_i.src2 : req_data_i.src2;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= 6'd0;
        end else begin
            case (state)
                S_IDLE: if (start) begin
                    state <= S_BUSY;
                    cnt   <= 6'(STEPS - 1);
                end
                S_BUSY: begin
                    cnt <= cnt - 6'd1;
                    if (cnt == 6'd0) state <= S_ACK;
                end
                // Ack held until the requester lets go
                default: if (!req_i) state <= S_IDLE;
            endcase
        end
    end

    // Shift-add and restoring steps, MD_STEP_BITS per cycle
    always_comb begin
        prod_nx = prod;
        rem_nx  = rem;
        quo_nx  = quo;
        for (int i = 0; i < MD_STEP_BITS; i++) begin
            if (mplier[i]) prod_nx = prod_nx + (mcand << i);
            rem_nx = {rem_nx[31:0], quo_nx[31]};
            quo_nx = {quo_nx[30:0], 1'b0};
            if (rem_nx >= {1'b0, dvsr}) begin
                rem_nx    = rem_nx - {1'b0, dvsr};
                quo_nx[0] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q      <= req_data_i.op;
            // Zero divisor keeps the all-ones quotient unsigned
            neg_q     <= (a_neg ^ b_neg) && (req_data_i.src2 != 32'b0);
            neg_rem_q <= a_neg;
            prod      <= 64'b0;
            mcand     <= {32'b0, a_mag};
            mplier    <= b_mag;
            rem       <= 33'b0;
            quo       <= a_mag;
            dvsr      <= b_mag;
        end else if (state == S_BUSY) begin
            prod   <= prod_nx;
            mcand  <= mcand << MD_STEP_BITS;
            mplier <= mplier >> MD_STEP_BITS;
            rem    <= rem_nx;
            quo    <= quo_nx;
        end
    end

    assign prod_fix = neg_q ? -prod : prod;

    always_comb begin
        case (op_q)
            MD_MUL:              result_o = prod_fix[31:0];
            MD_MULH, MD_MULHU:   result_o = prod_fix[63:32];
            MD_DIV, MD_DIVU:     result_o = neg_q ? -quo : quo;
            default:             result_o = neg_rem_q ? -rem[31:0] : rem[31:0];
        endcase
    end

endmodule

/* design/ex_alu.sv */
`timescale 1ns/100ps

module ex_alu (
    input  ex_pkg::ex_op_e op_i,
    input  logic [31:0]    src1_i,
    input  logic [31:0]    src2_i,
    input  logic [31:0]    imm_i,
    output logic [31:0]    result_o
);
    import ex_pkg::*;

    logic [4:0]  shamt;
    logic        lt_signed;
    logic        lt_unsigned;
    logic [31:0] sum;
    logic [31:0] diff;

    assign shamt       = src2_i[4:0];
    assign sum         = src1_i + src2_i;
    assign diff        = src1_i - src2_i;
    assign lt_signed   = $signed(src1_i) < $signed(src2_i);
    assign lt_unsigned = src1_i < src2_i;

    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = sum;
            end
            OP_SUB: begin
                result_o = diff;
            end
            OP_AND: begin
                result_o = src1_i & src2_i;
            end
            OP_OR: begin
                result_o = src1_i | src2_i;
            end
            OP_XOR: begin
                result_o = src1_i ^ src2_i;
            end
            OP_SLL: begin
                result_o = src1_i << shamt;
            end
            OP_SRL: begin
                result_o = src1_i >> shamt;
            end
            OP_SRA: begin
                result_o = $unsigned($signed(src1_i) >>> shamt);
            end
            OP_SLT: begin
                result_o = {31'b0, lt_signed};
            end
            OP_SLTU: begin
                result_o = {31'b0, lt_unsigned};
            end
            // Upper immediate already placed in src2 by dispatch
            OP_LUI: begin
                result_o = src2_i;
            end
            default: begin
                result_o = 32'b0;
            end
        endcase
    end

endmodule

/* design/ex_pkg.sv */
package ex_pkg;

    // Execute operations, one 5-bit word from dispatch
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        OP_MUL,
        OP_MULH,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_MOD,
        OP_MODU,
        OP_LD_B,
        OP_LD_H,
        OP_LD_W,
        OP_ST_B,
        OP_ST_H,
        OP_ST_W,
        OP_NOP
    } ex_op_e;

    // Multi-cycle unit operations
    typedef enum logic [2:0] {
        MD_MUL,
        MD_MULH,
        MD_MULHU,
        MD_DIV,
        MD_DIVU,
        MD_MOD,
        MD_MODU
    } md_op_e;

    typedef struct packed {
        logic        valid;
        ex_op_e      op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] imm;
        logic [4:0]  waddr;
        logic        wreg;
        logic [31:0] pc;
    } ex_in_t;

    typedef struct packed {
        logic                 valid;
        ex_op_e               op;
        logic [31:0]          wdata;
        logic [4:0]           waddr;
        logic                 wreg;
        logic [31:0]          mem_addr;
        logic [31:0]          st_data;
        logic                 excp_ale;
        xlate_pkg::xlate_req_t xreq;
    } ex_out_t;

    typedef struct packed {
        md_op_e      op;
        logic [31:0] src1;
        logic [31:0] src2;
    } md_req_t;

endpackage

/* design/xlate_pkg.sv */
package xlate_pkg;

    // Field view of a direct-mapped window CSR
    typedef struct packed {
        logic [2:0]  vseg;
        logic [24:0] rsvd_hi;
        logic        plv3;
        logic [1:0]  rsvd_lo;
        logic        plv0;
    } dmw_fields_t;

    // Written raw by the CSR block, decoded as fields here
    typedef union packed {
        logic [31:0] raw;
        dmw_fields_t f;
    } dmw_u;

    typedef struct packed {
        logic       da;
        logic       pg;
        logic [1:0] plv;
        dmw_u       dmw0;
        dmw_u       dmw1;
    } xlate_csr_t;

    // Request to the data TLB
    typedef struct packed {
        logic        fetch;
        logic        trans_en;
        logic        dmw0_hit;
        logic        dmw1_hit;
        logic [31:0] vaddr;
    } xlate_req_t;

endpackage
